//--- src/pat_pkg.sv
package pat_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int I_WIDTH        = 20;  // instruction word
	localparam int I_ADR_WIDTH    = 10;  // instruction address
	localparam int D_WIDTH        = 8;   // datapath
	localparam int DMEM_ADR_WIDTH = 4;   // low bits of imm8 only
	localparam int FIELDP_WIDTH   = 5;   // byte within a field buffer
	localparam int BUFP_WIDTH     = 3;   // buffer select
	localparam int LINE_INSTRS    = 2;   // instructions per imem line

	typedef logic [I_WIDTH-1:0]             instr_t;
	typedef logic [I_ADR_WIDTH-1:0]         iaddr_t;
	typedef logic [LINE_INSTRS*I_WIDTH-1:0] iline_t;  // even instr in low half
	typedef logic [D_WIDTH-1:0]             data_t;
	typedef logic [DMEM_ADR_WIDTH-1:0]      dadr_t;
	typedef logic [FIELDP_WIDTH-1:0]        fieldp_t;
	typedef logic [BUFP_WIDTH-1:0]          bufp_t;

	// ========================================
	// opcode spaces
	// ========================================
	// 8-bit immediate class, instr[11:8]
	typedef enum logic [3:0] {
		op8_or   = 4'h0,
		op8_and  = 4'h1,
		op8_addm = 4'h2,
		op8_subm = 4'h3,
		op8_add  = 4'h4,
		op8_sub  = 4'h5,
		op8_ldi  = 4'h6,
		op8_ldm  = 4'h7,
		op8_bf   = 4'h8,
		op8_stm  = 4'hB,
		op8_pfx3 = 4'hF   // escape into the 3-bit class
	} op8_e;

	// 3-bit immediate class, instr[7:4]
	typedef enum logic [3:0] {
		op3_shl  = 4'h0,
		op3_shlo = 4'h1,
		op3_shr  = 4'h2,
		op3_asr  = 4'h3,
		op3_in   = 4'h5,
		op3_out  = 4'h8,
		op3_setb = 4'h9,
		op3_pfx0 = 4'hF   // escape into the no-immediate class
	} op3_e;

	// no-immediate class, instr[3:0]
	typedef enum logic [3:0] {
		op0_not  = 4'h0,
		op0_mov  = 4'h1,
		op0_test = 4'h2,
		op0_nop  = 4'hF
	} op0_e;

	// ten alu functions, so four bits
	typedef enum logic [3:0] {
		alu_or, alu_and, alu_not, alu_add, alu_sub,
		alu_shl, alu_shlo, alu_shr, alu_asr,
		alu_pass  // forwards operand b
	} alu_op_e;

	typedef enum logic [1:0] {
		cond_al  = 2'd0,
		cond_n   = 2'd1,  // negative flag set
		cond_z   = 2'd2,  // zero flag set
		cond_al3 = 2'd3   // also always
	} cond_e;

	// cond always, no-immediate class, op0 5 (unlisted, so nop)
	localparam instr_t INSTR_NOP = 20'h06FF5;

endpackage

//--- src/pat_alu.sv
`timescale 1ns/1ps

module pat_alu (
	input  pat_pkg::alu_op_e  i_op,
	input  pat_pkg::data_t    i_a,
	input  pat_pkg::data_t    i_b,
	output pat_pkg::data_t    o_y
);
	import pat_pkg::*;

	logic [2:0] shamt;  // shifts only look at b[2:0]
	data_t      fill;   // ones shifted in by shlo

	assign shamt = i_b[2:0];
	assign fill  = ~({D_WIDTH{1'b1}} << shamt);

	// ========================================
	// function select
	// ========================================
	always_comb
	begin
		case (i_op)
			alu_or:
				o_y = i_a | i_b;
			alu_and:
				o_y = i_a & i_b;
			alu_not:
				o_y = ~i_a;             // b unused
			alu_add:
				o_y = i_a + i_b;        // modulo 256
			alu_sub:
				o_y = i_a - i_b;
			alu_shl:
				o_y = i_a << shamt;
			alu_shlo:
				o_y = (i_a << shamt) | fill;
			alu_shr:
				o_y = i_a >> shamt;     // zero fill
			alu_asr:
				o_y = data_t'($signed(i_a) >>> shamt);  // sign kept
			default:
				o_y = i_b;              // pass
		endcase
	end

endmodule

//--- src/pat_data_mem.sv
`timescale 1ns/1ps

module pat_data_mem (
	input  logic            clk,
	input  pat_pkg::dadr_t  i_rd_adr,
	input  logic            i_we,
	input  pat_pkg::dadr_t  i_wr_adr,
	input  pat_pkg::data_t  i_wdata,
	output pat_pkg::data_t  o_rdata
);
	import pat_pkg::*;

	data_t mem [2**DMEM_ADR_WIDTH];  // sixteen bytes, no init

	assign o_rdata = mem[i_rd_adr];  // async read

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_wr_adr] <= i_wdata;
	end

endmodule

//--- src/pat_fetch.sv
`timescale 1ns/1ps

module pat_fetch (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              i_redirect,   // taken bf in decode
	input  pat_pkg::iaddr_t                   i_target,
	input  pat_pkg::iline_t                   i_imem_line,  // answered same cycle
	output logic [pat_pkg::I_ADR_WIDTH-2:0]   o_imem_adr,   // line address
	output pat_pkg::instr_t                   o_instr,
	output pat_pkg::iaddr_t                   o_instr_adr,
	output logic                              o_valid
);
	import pat_pkg::*;

	iaddr_t pc;
	instr_t hi_hold;     // upper half of the last line read
	logic   fresh;       // first fetch after reset or redirect
	logic   read_line;
	instr_t line_lo;
	instr_t line_hi;
	instr_t instr_next;

	assign o_imem_adr = pc[I_ADR_WIDTH-1:1];  // two instrs per line
	assign line_lo    = i_imem_line[I_WIDTH-1:0];
	assign line_hi    = i_imem_line[LINE_INSTRS*I_WIDTH-1:I_WIDTH];

	// even pc starts a new line; an odd target has nothing held yet
	assign read_line = !pc[0] || fresh;

	always_comb
	begin
		if (read_line)
			instr_next = pc[0] ? line_hi : line_lo;
		else
			instr_next = hi_hold;  // odd pc, reuse the line
	end

	// line buffer, payload only
	always_ff @(posedge clk)
	begin
		if (read_line)
			hi_hold <= line_hi;
	end

	// ========================================
	// pc and fetch register
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc      <= '0;
			o_instr <= INSTR_NOP;
			o_valid <= 1'b0;
			fresh   <= 1'b1;
		end
		else if (i_redirect)
		begin
			pc      <= i_target;
			o_instr <= INSTR_NOP;  // kill the instr behind the branch
			o_valid <= 1'b0;
			fresh   <= 1'b1;
		end
		else
		begin
			pc      <= pc + 1'b1;
			o_instr <= instr_next;
			o_valid <= 1'b1;
			fresh   <= 1'b0;
		end
		o_instr_adr <= pc;  // address travels with the instr
	end

endmodule

//--- src/pat_decode.sv
`timescale 1ns/1ps

module pat_decode (
	input  logic              clk,
	input  logic              reset,
	input  pat_pkg::instr_t   i_instr,
	input  pat_pkg::iaddr_t   i_instr_adr,
	input  logic              i_valid,
	output logic              o_redirect,   // to fetch, same cycle
	output pat_pkg::iaddr_t   o_target,
	output pat_pkg::alu_op_e  o_alu_op,
	output pat_pkg::data_t    o_imm,
	output pat_pkg::cond_e    o_cond,
	output pat_pkg::fieldp_t  o_fieldp,
	output logic              o_field_op,
	output logic              o_src_mem,
	output logic              o_src_in,
	output logic              o_dest_reg,
	output logic              o_dest_mem,
	output logic              o_mov,
	output logic              o_test,
	output logic              o_out,
	output logic              o_setb,
	output logic              o_valid
);
	import pat_pkg::*;

	fieldp_t    fieldp;
	logic [1:0] cond_raw;
	logic       field_op;
	logic [3:0] op8, op3, op0;
	data_t      imm8;
	logic       cls8, cls3, cls0;   // instruction class
	logic       op_or, op_and, op_addm, op_subm, op_add, op_sub, op_ldi, op_ldm;
	logic       op_bf, op_stm;
	logic       op_shl, op_shlo, op_shr, op_asr, op_in, op_out, op_setb;
	logic       op_not, op_mov, op_test;
	logic       dest_reg;
	alu_op_e    alu_op;
	data_t      imm;

	// ========================================
	// instruction split and class
	// ========================================
	assign {fieldp, cond_raw, field_op, op8, imm8} = i_instr;
	assign op3 = imm8[7:4];
	assign op0 = imm8[3:0];

	assign cls8 = (op8 != op8_pfx3);
	assign cls3 = (op8 == op8_pfx3) && (op3 != op3_pfx0);
	assign cls0 = !cls8 && !cls3;

	assign op_or   = cls8 && (op8 == op8_or);
	assign op_and  = cls8 && (op8 == op8_and);
	assign op_addm = cls8 && (op8 == op8_addm);
	assign op_subm = cls8 && (op8 == op8_subm);
	assign op_add  = cls8 && (op8 == op8_add);
	assign op_sub  = cls8 && (op8 == op8_sub);
	assign op_ldi  = cls8 && (op8 == op8_ldi);
	assign op_ldm  = cls8 && (op8 == op8_ldm);
	assign op_bf   = cls8 && (op8 == op8_bf);
	assign op_stm  = cls8 && (op8 == op8_stm);
	assign op_shl  = cls3 && (op3 == op3_shl);
	assign op_shlo = cls3 && (op3 == op3_shlo);
	assign op_shr  = cls3 && (op3 == op3_shr);
	assign op_asr  = cls3 && (op3 == op3_asr);
	assign op_in   = cls3 && (op3 == op3_in);
	assign op_out  = cls3 && (op3 == op3_out);
	assign op_setb = cls3 && (op3 == op3_setb);
	assign op_not  = cls0 && (op0 == op0_not);
	assign op_mov  = cls0 && (op0 == op0_mov);
	assign op_test = cls0 && (op0 == op0_test);

	// everything that lands in acc or field byte
	assign dest_reg = op_or | op_and | op_addm | op_subm | op_add | op_sub | op_ldi | op_ldm
		| op_shl | op_shlo | op_shr | op_asr | op_in | op_not | op_mov;

	// 3-bit class keeps imm8 bit 3 too, setb takes the bank from it
	assign imm = cls8 ? imm8 : {4'b0000, imm8[3:0]};

	always_comb
	begin
		if (op_or)                alu_op = alu_or;
		else if (op_and)          alu_op = alu_and;
		else if (op_add | op_addm) alu_op = alu_add;
		else if (op_sub | op_subm) alu_op = alu_sub;
		else if (op_shl)          alu_op = alu_shl;
		else if (op_shlo)         alu_op = alu_shlo;
		else if (op_shr)          alu_op = alu_shr;
		else if (op_asr)          alu_op = alu_asr;
		else if (op_not)          alu_op = alu_not;
		else                      alu_op = alu_pass;  // ldi, ldm, in pick b
	end

	// bf is relative to its own address, signed offset
	assign o_redirect = i_valid && op_bf;
	assign o_target   = i_instr_adr + {{(I_ADR_WIDTH-D_WIDTH){imm8[D_WIDTH-1]}}, imm8};

	// ========================================
	// stage-two register
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_valid    <= 1'b0;
			o_dest_reg <= 1'b0;
			o_dest_mem <= 1'b0;
			o_test     <= 1'b0;
			o_out      <= 1'b0;
			o_setb     <= 1'b0;
		end
		else
		begin
			o_valid    <= i_valid;
			o_dest_reg <= dest_reg;
			o_dest_mem <= op_stm;
			o_test     <= op_test;
			o_out      <= op_out;
			o_setb     <= op_setb;
		end
		o_alu_op   <= alu_op;
		o_imm      <= imm;
		o_cond     <= cond_e'(cond_raw);
		o_fieldp   <= fieldp;
		o_field_op <= field_op;
		o_src_mem  <= op_ldm | op_addm | op_subm;
		o_src_in   <= op_in;
		o_mov      <= op_mov;
	end

endmodule

//--- src/pat_execute.sv
`timescale 1ns/1ps

module pat_execute (
	input  logic              clk,
	input  logic              reset,
	input  pat_pkg::alu_op_e  i_alu_op,
	input  pat_pkg::data_t    i_imm,
	input  pat_pkg::cond_e    i_cond,
	input  pat_pkg::fieldp_t  i_fieldp,
	input  logic              i_field_op,
	input  logic              i_src_mem,
	input  logic              i_src_in,
	input  logic              i_dest_reg,
	input  logic              i_dest_mem,
	input  logic              i_mov,
	input  logic              i_test,
	input  logic              i_out,
	input  logic              i_setb,
	input  logic              i_valid,
	input  pat_pkg::data_t    i_field_low,
	input  pat_pkg::data_t    i_field_high,
	input  pat_pkg::data_t    i_inputs,
	input  pat_pkg::data_t    i_dmem_rdata,
	output pat_pkg::dadr_t    o_dmem_adr,    // shared read and write address
	output logic              o_dmem_we,
	output pat_pkg::data_t    o_dmem_wdata,
	output pat_pkg::fieldp_t  o_field_adr,
	output pat_pkg::bufp_t    o_bufp,
	output logic              o_field_bank,  // 1 selects the high bank
	output logic              o_field_we_low,
	output logic              o_field_we_high,
	output pat_pkg::data_t    o_field_wdata,
	output pat_pkg::data_t    o_outputs,
	output logic              o_out_valid
);
	import pat_pkg::*;

	data_t acc;
	data_t field_byte;
	data_t opnd_b;
	data_t acc_y, field_y;
	data_t test_val;
	logic  z_flag, n_flag;
	logic  cond_ok;
	logic  commit;
	logic  field_we;

	// ========================================
	// operands and alus
	// ========================================
	assign o_field_adr = i_fieldp;
	assign field_byte  = o_field_bank ? i_field_high : i_field_low;
	assign o_dmem_adr  = i_imm[DMEM_ADR_WIDTH-1:0];
	assign opnd_b      = i_src_in ? i_inputs : (i_src_mem ? i_dmem_rdata : i_imm);

	pat_alu acc_alu (.i_op(i_alu_op), .i_a(acc), .i_b(opnd_b), .o_y(acc_y));
	pat_alu field_alu (.i_op(i_alu_op), .i_a(field_byte), .i_b(opnd_b), .o_y(field_y));

	always_comb
	begin
		case (i_cond)
			cond_n:  cond_ok = n_flag;
			cond_z:  cond_ok = z_flag;
			default: cond_ok = 1'b1;   // both always codes
		endcase
	end
	assign commit = i_valid && cond_ok;

	// field and memory writes land on this cycle's edge
	assign field_we        = commit && i_dest_reg && i_field_op;
	assign o_field_we_low  = field_we && !o_field_bank;
	assign o_field_we_high = field_we && o_field_bank;
	assign o_field_wdata   = i_mov ? acc : field_y;   // mov into field takes acc
	assign o_dmem_we       = commit && i_dest_mem;
	assign o_dmem_wdata    = i_field_op ? field_byte : acc;
	assign test_val        = i_field_op ? field_byte : acc;

	// ========================================
	// architectural registers
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc          <= '0;
			z_flag       <= 1'b0;
			n_flag       <= 1'b0;
			o_bufp       <= '0;
			o_field_bank <= 1'b0;
			o_outputs    <= '0;
			o_out_valid  <= 1'b0;
		end
		else
		begin
			o_out_valid <= commit && i_out;  // pulse with the new value
			if (commit && i_dest_reg && !i_field_op)
				acc <= i_mov ? field_byte : acc_y;
			if (commit && i_test)
			begin
				z_flag <= (test_val == '0);
				n_flag <= test_val[D_WIDTH-1];
			end
			if (commit && i_out)
				o_outputs <= acc;
			if (commit && i_setb)
			begin
				o_bufp       <= i_imm[BUFP_WIDTH-1:0];
				o_field_bank <= i_imm[BUFP_WIDTH];  // imm bit 3
			end
		end
	end

endmodule

//--- src/pat_top.sv
`timescale 1ns/1ps

module pat_top (
	input  logic                             clk,
	input  logic                             reset,
	input  pat_pkg::iline_t                  i_imem_line,
	input  pat_pkg::data_t                   i_field_low,
	input  pat_pkg::data_t                   i_field_high,
	input  pat_pkg::data_t                   i_inputs,
	output logic [pat_pkg::I_ADR_WIDTH-2:0]  o_imem_adr,
	output pat_pkg::fieldp_t                 o_field_adr,
	output pat_pkg::bufp_t                   o_bufp,
	output logic                             o_field_bank,
	output logic                             o_field_we_low,
	output logic                             o_field_we_high,
	output pat_pkg::data_t                   o_field_wdata,
	output pat_pkg::data_t                   o_outputs,
	output logic                             o_out_valid
);
	import pat_pkg::*;

	// fetch <-> decode
	instr_t  f_instr;
	iaddr_t  f_instr_adr, d_target;
	logic    f_valid, d_redirect;
	// decode -> execute
	alu_op_e d_alu_op;
	data_t   d_imm;
	cond_e   d_cond;
	fieldp_t d_fieldp;
	logic    d_field_op, d_src_mem, d_src_in, d_dest_reg, d_dest_mem;
	logic    d_mov, d_test, d_out, d_setb, d_valid;
	// execute <-> data memory
	dadr_t   dm_adr;
	logic    dm_we;
	data_t   dm_wdata, dm_rdata;

	pat_fetch u_fetch (
		.clk(clk), .reset(reset), .i_redirect(d_redirect), .i_target(d_target),
		.i_imem_line(i_imem_line), .o_imem_adr(o_imem_adr), .o_instr(f_instr),
		.o_instr_adr(f_instr_adr), .o_valid(f_valid));

	pat_decode u_decode (
		.clk(clk), .reset(reset), .i_instr(f_instr), .i_instr_adr(f_instr_adr),
		.i_valid(f_valid), .o_redirect(d_redirect), .o_target(d_target),
		.o_alu_op(d_alu_op), .o_imm(d_imm), .o_cond(d_cond), .o_fieldp(d_fieldp),
		.o_field_op(d_field_op), .o_src_mem(d_src_mem), .o_src_in(d_src_in),
		.o_dest_reg(d_dest_reg), .o_dest_mem(d_dest_mem), .o_mov(d_mov),
		.o_test(d_test), .o_out(d_out), .o_setb(d_setb), .o_valid(d_valid));

	pat_execute u_execute (
		.clk(clk), .reset(reset), .i_alu_op(d_alu_op), .i_imm(d_imm), .i_cond(d_cond),
		.i_fieldp(d_fieldp), .i_field_op(d_field_op), .i_src_mem(d_src_mem),
		.i_src_in(d_src_in), .i_dest_reg(d_dest_reg), .i_dest_mem(d_dest_mem),
		.i_mov(d_mov), .i_test(d_test), .i_out(d_out), .i_setb(d_setb),
		.i_valid(d_valid), .i_field_low(i_field_low), .i_field_high(i_field_high),
		.i_inputs(i_inputs), .i_dmem_rdata(dm_rdata), .o_dmem_adr(dm_adr),
		.o_dmem_we(dm_we), .o_dmem_wdata(dm_wdata), .o_field_adr(o_field_adr),
		.o_bufp(o_bufp), .o_field_bank(o_field_bank), .o_field_we_low(o_field_we_low),
		.o_field_we_high(o_field_we_high), .o_field_wdata(o_field_wdata),
		.o_outputs(o_outputs), .o_out_valid(o_out_valid));

	pat_data_mem u_dmem (
		.clk(clk), .i_rd_adr(dm_adr), .i_we(dm_we), .i_wr_adr(dm_adr),
		.i_wdata(dm_wdata), .o_rdata(dm_rdata));

endmodule

//--- test/pat_clk_gen.sv
`timescale 1ns/1ps

module pat_clk_gen (
	output logic clk,
	output logic reset
);
	localparam int HALF_PERIOD  = 10;  // 20 ns clock
	localparam int RESET_CYCLES = 2;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release just after an edge, like the other inputs
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

//--- test/pat_chk.sv
`timescale 1ns/1ps

module pat_chk (
	input logic                             clk,
	input logic                             reset,
	input logic [pat_pkg::I_ADR_WIDTH-2:0]  i_imem_adr,
	input logic                             i_field_we_low,
	input logic                             i_field_we_high,
	input logic                             i_out_valid
);

	// ========================================
	// field buffer and strobes
	// ========================================
	// one bank per write
	a_we_one_bank: assert property (@(posedge clk) disable iff (reset)
		!(i_field_we_low && i_field_we_high))
		else $error("both field write enables high in one cycle");

	// second reset cycle on, the strobes must be quiet
	a_quiet_in_reset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> (!i_out_valid && !i_field_we_low && !i_field_we_high))
		else $error("strobe active while reset is held");

	// line address must be known once running
	a_imem_adr_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(i_imem_adr))
		else $error("instruction line address has unknown bits");

endmodule

//--- test/pat_tb.sv
`timescale 1ns/1ps

module pat_tb;
	import pat_pkg::*;

	localparam int PROG_LEN       = 400;
	localparam int PRO_LEN        = 32;             // ldi/stm pairs for all of dmem
	localparam int EPI_START      = PROG_LEN - 33;  // ldm/out dump plus final bf
	localparam int TIMEOUT_CYCLES = 4 * PROG_LEN + 100;
	localparam logic [3:0] BODY_OP8 [9] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hB};
	localparam logic [3:0] BODY_OP3 [7] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h5, 4'h8, 4'h9};
	localparam logic [3:0] BODY_OP0 [4] = '{4'h0, 4'h1, 4'h2, 4'hF};

	logic clk, reset;
	iline_t i_imem_line;
	data_t i_field_low, i_field_high, i_inputs;
	logic [I_ADR_WIDTH-2:0] o_imem_adr;
	fieldp_t o_field_adr;
	bufp_t o_bufp;
	logic o_field_bank, o_field_we_low, o_field_we_high, o_out_valid;
	data_t o_field_wdata, o_outputs;

	integer seed = 32'ha192_f741;
	instr_t prog [1024];      // program memory, one instr per word
	data_t fbuf [2][8][32];   // bank, buffer, byte
	data_t mfbuf [2][8][32];  // model's copy
	data_t in_val;            // fixed value on the input port
	data_t out_q [$];          // expected out values, in order
	logic [16:0] fw_q [$];     // {bank, bufp, adr, data}
	logic [16:0] exp_fw;
	int cycle_count = 0;

	pat_clk_gen u_clk_gen (.clk(clk), .reset(reset));

	pat_top i_dut (
		.clk(clk), .reset(reset), .i_imem_line(i_imem_line), .i_field_low(i_field_low),
		.i_field_high(i_field_high), .i_inputs(i_inputs), .o_imem_adr(o_imem_adr),
		.o_field_adr(o_field_adr), .o_bufp(o_bufp), .o_field_bank(o_field_bank),
		.o_field_we_low(o_field_we_low), .o_field_we_high(o_field_we_high),
		.o_field_wdata(o_field_wdata), .o_outputs(o_outputs), .o_out_valid(o_out_valid));

	bind pat_top pat_chk u_chk (
		.clk(clk), .reset(reset), .i_imem_adr(o_imem_adr), .i_field_we_low(o_field_we_low),
		.i_field_we_high(o_field_we_high), .i_out_valid(o_out_valid));

	// memories answer in the same cycle
	assign i_imem_line  = {prog[{o_imem_adr, 1'b1}], prog[{o_imem_adr, 1'b0}]};
	assign i_field_low  = fbuf[0][o_bufp][o_field_adr];
	assign i_field_high = fbuf[1][o_bufp][o_field_adr];

	always @(posedge clk)
	begin
		if (!reset && o_field_we_low)
			fbuf[0][o_bufp][o_field_adr] <= o_field_wdata;
		if (!reset && o_field_we_high)
			fbuf[1][o_bufp][o_field_adr] <= o_field_wdata;
	end

	// ========================================
	// checks
	// ========================================
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_fieldp(input string name, input fieldp_t got, input fieldp_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bufp(input string name, input bufp_t got, input bufp_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_iaddr(input string name, input iaddr_t got, input iaddr_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bank(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// ========================================
	// program generator
	// ========================================
	function automatic int pick(input int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic instr_t make_instr(input fieldp_t fp, input logic [1:0] cd,
		input logic fo, input logic [3:0] op, input data_t imm);
		return {fp, cd, fo, op, imm};
	endfunction

	task automatic build_program;
		int k, kind, off;
		fieldp_t fp;
		logic [1:0] cd;
		logic fo;
		data_t r8;
		for (k = 0; k < 1024; k++)
			prog[k] = INSTR_NOP;
		for (k = 0; k < 16; k++)
		begin
			prog[2*k]   = make_instr('0, 2'd0, 1'b0, op8_ldi, data_t'($random(seed)));
			prog[2*k+1] = make_instr('0, 2'd0, 1'b0, op8_stm, data_t'(k));
		end
		for (k = PRO_LEN; k < EPI_START; k++)
		begin
			fp   = fieldp_t'(pick(32));
			cd   = 2'(pick(4));
			fo   = 1'(pick(2));
			r8   = data_t'($random(seed));
			kind = pick(24);  // 21..23 add extra tests to move the flags
			if (kind < 9)
				prog[k] = make_instr(fp, cd, fo, BODY_OP8[kind], r8);
			else if (kind == 9)
			begin
				off = 1 + pick(6);  // forward only
				if (k + off > EPI_START)
					off = EPI_START - k;
				prog[k] = make_instr(fp, cd, fo, op8_bf, data_t'(off));
			end
			else if (kind < 17)
				prog[k] = make_instr(fp, cd, fo, op8_pfx3, {BODY_OP3[kind-10], r8[3:0]});
			else if (kind < 21)
				prog[k] = make_instr(fp, cd, fo, op8_pfx3, {op3_pfx0, BODY_OP0[kind-17]});
			else
				prog[k] = make_instr(fp, cd, fo, op8_pfx3, {op3_pfx0, op0_test});
		end
		for (k = 0; k < 16; k++)
		begin
			prog[EPI_START+2*k]   = make_instr('0, 2'd0, 1'b0, op8_ldm, data_t'(k));
			prog[EPI_START+2*k+1] = make_instr('0, 2'd0, 1'b0, op8_pfx3, {op3_out, 4'h0});
		end
		prog[PROG_LEN-1] = make_instr('0, 2'd0, 1'b0, op8_bf, 8'h00);  // park here
	endtask

	// ========================================
	// instruction model
	// ========================================
	function automatic data_t shift_model(input data_t a, input logic [2:0] s,
		input logic [3:0] op);
		data_t r;
		r = a;
		for (int i = 0; i < int'(s); i++)
			case (op)
				op3_shl:  r = {r[6:0], 1'b0};
				op3_shlo: r = {r[6:0], 1'b1};  // ones come in
				op3_shr:  r = {1'b0, r[7:1]};
				default:  r = {r[7], r[7:1]};  // asr
			endcase
		return r;
	endfunction

	task automatic run_model;
		iaddr_t pc, next_pc;
		instr_t ins;
		data_t acc, fb, a, b, res, imm8;
		data_t dm [16];
		logic z, n, bank, fo, ok, dest, done;
		bufp_t bp;
		fieldp_t fp;
		logic [3:0] op8, op3, op0;
		int steps;
		pc = '0;
		acc = '0;
		z = 1'b0;
		n = 1'b0;
		bank = 1'b0;
		bp = '0;
		done = 1'b0;
		steps = 0;
		for (int k = 0; k < 16; k++)
			dm[k] = '0;
		while (!done)
		begin
			ins  = prog[pc];
			fp   = ins[19:15];
			fo   = ins[12];
			op8  = ins[11:8];
			imm8 = ins[7:0];
			op3  = imm8[7:4];
			op0  = imm8[3:0];
			case (ins[14:13])
				2'd1:    ok = n;
				2'd2:    ok = z;
				default: ok = 1'b1;
			endcase
			fb      = mfbuf[bank][bp][fp];
			a       = fo ? fb : acc;
			b       = dm[imm8[3:0]];
			dest    = 1'b1;
			res     = '0;
			next_pc = pc + 10'd1;
			if (op8 != 4'hF)
				case (op8)
					op8_or:   res = a | imm8;
					op8_and:  res = a & imm8;
					op8_addm: res = a + b;
					op8_subm: res = a - b;
					op8_add:  res = a + imm8;
					op8_sub:  res = a - imm8;
					op8_ldi:  res = imm8;
					op8_ldm:  res = b;
					op8_bf:
					begin
						dest    = 1'b0;  // taken whatever the condition
						done    = (imm8 == 8'h00);
						next_pc = pc + {{2{imm8[7]}}, imm8};
					end
					op8_stm:
					begin
						dest = 1'b0;
						if (ok)
							dm[imm8[3:0]] = a;
					end
					default: dest = 1'b0;
				endcase
			else if (op3 != 4'hF)
				case (op3)
					op3_shl, op3_shlo, op3_shr, op3_asr: res = shift_model(a, imm8[2:0], op3);
					op3_in: res = in_val;
					op3_out:
					begin
						dest = 1'b0;
						if (ok)
							out_q.push_back(acc);
					end
					op3_setb:
					begin
						dest = 1'b0;
						if (ok)
						begin
							bp   = imm8[2:0];
							bank = imm8[3];
						end
					end
					default: dest = 1'b0;
				endcase
			else
				case (op0)
					op0_not: res = ~a;
					op0_mov: res = fo ? acc : fb;  // crosses acc and field byte
					op0_test:
					begin
						dest = 1'b0;
						if (ok)
						begin
							z = (a == 8'h00);
							n = a[7];
						end
					end
					default: dest = 1'b0;  // nop and unlisted
				endcase
			if (ok && dest && fo)
			begin
				mfbuf[bank][bp][fp] = res;
				fw_q.push_back({bank, bp, fp, res});
			end
			else if (ok && dest)
				acc = res;
			pc    = next_pc;
			steps = steps + 1;
			if (steps > PROG_LEN)
				fail_run("model ran past the program without reaching the final branch");
		end
	endtask

	// ========================================
	// stimulus, monitors and timeout
	// ========================================
	always @(negedge clk)
	begin
		if (!reset && o_out_valid)
		begin
			if (out_q.size() == 0)
				fail_run("out strobe fired with no out value left in the model");
			else
				check_data("o_outputs", o_outputs, out_q.pop_front());
		end
		if (!reset && (o_field_we_low || o_field_we_high))
		begin
			if (fw_q.size() == 0)
				fail_run("field write strobe fired with no write left in the model");
			else
			begin
				exp_fw = fw_q.pop_front();
				check_bank("o_field_bank", o_field_bank, exp_fw[16]);
				check_bank("o_field_we_high", o_field_we_high, exp_fw[16]);
				check_bufp("o_bufp", o_bufp, exp_fw[15:13]);
				check_fieldp("o_field_adr", o_field_adr, exp_fw[12:8]);
				check_data("o_field_wdata", o_field_wdata, exp_fw[7:0]);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			fail_run($sformatf("timeout after %0d cycles with events still expected",
				TIMEOUT_CYCLES));
	end

	initial
	begin
		i_inputs = '0;
		build_program();
		for (int bk = 0; bk < 2; bk++)
			for (int u = 0; u < 8; u++)
				for (int ad = 0; ad < 32; ad++)
					fbuf[bk][u][ad] = data_t'($random(seed));
		mfbuf  = fbuf;
		in_val = data_t'($random(seed));
		run_model();
		@(posedge clk);
		#1 i_inputs = in_val;
		while (reset)
			@(posedge clk);
		@(negedge clk);
		check_iaddr("o_imem_adr", iaddr_t'({o_imem_adr, 1'b0}), '0);
		while (out_q.size() != 0 || fw_q.size() != 0)
			@(posedge clk);
		repeat (10) @(posedge clk);  // stray strobes after the last event
		$display("Regression passed");
		$finish;
	end

endmodule

//--- vlog.f
src/pat_pkg.sv
src/pat_alu.sv
src/pat_data_mem.sv
src/pat_fetch.sv
src/pat_decode.sv
src/pat_execute.sv
src/pat_top.sv
test/pat_clk_gen.sv
test/pat_chk.sv
test/pat_tb.sv

//--- Makefile
# Verilator build and run of the pat core testbench

VERILATOR  ?= verilator
TOP        ?= pat_tb
FLIST      ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell cat $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
